// ==== rtl/commit_macros.svh ====
`ifndef COMMIT_MACROS_SVH
`define COMMIT_MACROS_SVH

// data word width.
`define WORD_W 16

// architectural registers R0..R7.
`define NUM_REGS 8

// reorder buffer slots, also the sender's starting credit count.
// must stay a power of two so the slot pointers wrap on their own.
`define ROB_DEPTH 8

// TRAP leaves its return value here.
`define TRAP_LINK_REG 7

`endif

// ==== rtl/commit_pkg.sv ====
`include "commit_macros.svh"

package commit_pkg;

	typedef logic [`WORD_W-1:0] lc3b_word;               // data value or address.
	typedef logic [$clog2(`NUM_REGS)-1:0] lc3b_reg;      // register index, or nzp mask on BR.
	typedef logic [2:0] lc3b_nzp;                         // condition codes.
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;    // slot index, doubles as producer tag.

	// LC-3b opcode encodings for the subset that reaches commit.
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_trap = 4'b1111
	} lc3b_opcode;

	// one completed instruction waiting in the buffer.
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dest;          // destination, or nzp mask for BR.
		lc3b_word value;        // result, branch target or store data.
		lc3b_word addr;         // store address.
		logic predict;          // predicted taken.
	} rob_entry_t;

	typedef enum logic [1:0]
	{
		st_retire,
		st_store_wait,
		st_flush
	} commit_state_t;

	// what the controller tells the rest of the commit stage about the head.
	typedef struct packed
	{
		rob_entry_t entry;      // dest already remapped for TRAP.
		rob_idx_t idx;
		logic reg_we;
		logic cc_we;
		lc3b_nzp cc;            // codes derived from the retiring value.
	} retire_t;

endpackage

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "commit_macros.svh"

module reorder_buffer
(
	input logic clk,
	input logic rst_n,
	input logic enq_valid,
	input commit_pkg::rob_entry_t enq_entry,
	output commit_pkg::rob_idx_t alloc_idx,
	output logic head_valid,
	output commit_pkg::rob_entry_t head_entry,
	output commit_pkg::rob_idx_t head_idx,
	input logic retire,
	input logic flush,
	output logic credit_return
);

	localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

	commit_pkg::rob_entry_t slots [`ROB_DEPTH];
	commit_pkg::rob_idx_t head_ptr;
	commit_pkg::rob_idx_t tail_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_retire;

	assign full = (count == CNT_W'(`ROB_DEPTH));
	assign head_valid = (count != '0);
	assign head_entry = slots[head_ptr];
	assign head_idx = head_ptr;
	assign alloc_idx = tail_ptr;                  // slot the next entry lands in.
	assign do_retire = retire && head_valid;
	assign credit_return = do_retire;             // one credit per retired entry.

	always_ff @(posedge clk)
	begin
		if (enq_valid)
		begin
			slots[tail_ptr] <= enq_entry;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			// whole window is dropped, sender gets every credit back.
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enq_valid)
			begin
				tail_ptr <= tail_ptr + 1'b1;      // wraps at depth.
			end
			if (do_retire)
			begin
				head_ptr <= head_ptr + 1'b1;
			end
			count <= count + CNT_W'(enq_valid) - CNT_W'(do_retire);
		end
	end

	// sender must hold a credit, so a full buffer never sees an enqueue.
	a_no_enq_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(enq_valid && full))
		else $error("enqueue while reorder buffer is full");

	// the controller only retires a head that is really there.
	a_no_retire_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(retire && !head_valid))
		else $error("retire while reorder buffer is empty");

endmodule

// ==== rtl/commit_fsm.sv ====
`timescale 1ns/1ps
`include "commit_macros.svh"

module commit_fsm
(
	input logic clk,
	input logic rst_n,
	input logic head_valid,
	input commit_pkg::rob_entry_t head_entry,
	input commit_pkg::rob_idx_t head_idx,
	input commit_pkg::lc3b_nzp committed_cc,
	input logic dmem_resp,
	output logic retire,
	output commit_pkg::retire_t retire_info,
	output logic dmem_write,
	output commit_pkg::lc3b_word dmem_addr,
	output commit_pkg::lc3b_word dmem_wdata,
	output logic pc_redirect,
	output commit_pkg::lc3b_word new_pc,
	output logic flush,
	output logic branch_taken
);

	commit_pkg::commit_state_t state;
	commit_pkg::commit_state_t state_next;
	commit_pkg::lc3b_nzp value_cc;
	logic mispredict;

	always_comb
	begin
		if (head_entry.value[`WORD_W-1])
			value_cc = 3'b100;                        // negative.
		else if (head_entry.value == '0)
			value_cc = 3'b010;                        // zero.
		else
			value_cc = 3'b001;                        // positive.
	end

	assign branch_taken = |(head_entry.dest & committed_cc);
	assign mispredict = (branch_taken != head_entry.predict);

	// store outputs come straight from the head, which cannot move while waiting.
	assign dmem_write = (state == commit_pkg::st_store_wait);
	assign dmem_addr = head_entry.addr;
	assign dmem_wdata = head_entry.value;
	assign new_pc = head_entry.value;             // branch or trap target.

	always_comb
	begin
		state_next = state;
		retire = 1'b0;
		flush = 1'b0;
		pc_redirect = 1'b0;
		retire_info.entry = head_entry;
		retire_info.idx = head_idx;
		retire_info.reg_we = 1'b0;
		retire_info.cc_we = 1'b0;
		retire_info.cc = value_cc;
		case (state)
			commit_pkg::st_retire:
			begin
				if (head_valid)
				begin
					case (head_entry.opcode)
						commit_pkg::op_add, commit_pkg::op_and, commit_pkg::op_not:
						begin
							retire = 1'b1;
							retire_info.reg_we = 1'b1;
							retire_info.cc_we = 1'b1;
						end
						commit_pkg::op_jsr:
						begin
							retire = 1'b1;
							retire_info.reg_we = 1'b1;    // link value, codes untouched.
						end
						commit_pkg::op_trap:
						begin
							retire = 1'b1;
							retire_info.reg_we = 1'b1;
							retire_info.entry.dest = commit_pkg::lc3b_reg'(`TRAP_LINK_REG);
							flush = 1'b1;
							pc_redirect = 1'b1;
							state_next = commit_pkg::st_flush;
						end
						commit_pkg::op_br:
						begin
							retire = 1'b1;
							if (mispredict)
							begin
								flush = 1'b1;
								pc_redirect = 1'b1;
								state_next = commit_pkg::st_flush;
							end
						end
						commit_pkg::op_str:
						begin
							state_next = commit_pkg::st_store_wait;
						end
						default:
						begin
							retire = 1'b1;                // unknown opcode retires silently.
						end
					endcase
				end
			end
			commit_pkg::st_store_wait:
			begin
				if (dmem_resp)
				begin
					retire = 1'b1;
					state_next = commit_pkg::st_retire;
				end
			end
			commit_pkg::st_flush:
			begin
				state_next = commit_pkg::st_retire;   // bubble while fetch restarts.
			end
			default:
			begin
				state_next = commit_pkg::st_retire;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= commit_pkg::st_retire;
		else
			state <= state_next;
	end

	// store request stays up and steady until memory answers.
	a_store_held: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_write && !dmem_resp |=> dmem_write && $stable(dmem_addr) && $stable(dmem_wdata))
		else $error("store request dropped before dmem_resp");

endmodule

// ==== rtl/branch_stats.sv ====
`timescale 1ns/1ps

module branch_stats
(
	input logic clk,
	input logic rst_n,
	input logic retire,
	input commit_pkg::retire_t retire_info,
	input logic branch_taken,
	output commit_pkg::lc3b_word branch_count,
	output commit_pkg::lc3b_word mispredict_count
);

	logic is_branch;
	logic wrong_guess;

	assign is_branch = retire && (retire_info.entry.opcode == commit_pkg::op_br);
	assign wrong_guess = (branch_taken != retire_info.entry.predict);

	// counters run for the whole simulation, reset only.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			branch_count <= '0;
			mispredict_count <= '0;
		end
		else if (is_branch)
		begin
			branch_count <= branch_count + 1'b1;
			if (wrong_guess)
			begin
				mispredict_count <= mispredict_count + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/arch_regfile.sv ====
`timescale 1ns/1ps
`include "commit_macros.svh"

module arch_regfile
(
	input logic clk,
	input logic rst_n,
	input logic enq_valid,
	input commit_pkg::rob_entry_t enq_entry,
	input commit_pkg::rob_idx_t alloc_idx,
	input logic retire,
	input commit_pkg::retire_t retire_info,
	input logic flush,
	input commit_pkg::lc3b_reg rd_addr,
	output commit_pkg::lc3b_word rd_data,
	output logic rd_busy,
	output commit_pkg::lc3b_nzp committed_cc
);

	commit_pkg::lc3b_word regs [`NUM_REGS];
	commit_pkg::rob_idx_t tags [`NUM_REGS];       // newest producer per register.
	logic [`NUM_REGS-1:0] busy;
	commit_pkg::lc3b_nzp cc_q;
	commit_pkg::lc3b_reg enq_dest;
	commit_pkg::lc3b_reg ret_dest;
	logic enq_writes;
	logic ret_newest;

	always_comb
	begin
		enq_dest = enq_entry.dest;
		enq_writes = 1'b0;
		case (enq_entry.opcode)
			commit_pkg::op_add, commit_pkg::op_and, commit_pkg::op_not, commit_pkg::op_jsr:
				enq_writes = 1'b1;
			commit_pkg::op_trap:
			begin
				enq_writes = 1'b1;
				enq_dest = commit_pkg::lc3b_reg'(`TRAP_LINK_REG);
			end
			default: enq_writes = 1'b0;
		endcase
	end

	assign ret_dest = retire_info.entry.dest;
	assign ret_newest = (tags[ret_dest] == retire_info.idx);

	always_ff @(posedge clk)
	begin
		if (retire && retire_info.reg_we)
			regs[ret_dest] <= retire_info.entry.value;
		if (enq_valid && enq_writes)
			tags[enq_dest] <= alloc_idx;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= '0;
		else if (flush)
			busy <= '0;                               // nothing younger survives.
		else
		begin
			if (retire && retire_info.reg_we && ret_newest)
				busy[ret_dest] <= 1'b0;
			// a new producer overrides a clear on the same register.
			if (enq_valid && enq_writes)
				busy[enq_dest] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cc_q <= 3'b010;
		else if (retire && retire_info.cc_we)
			cc_q <= retire_info.cc;
	end

	assign committed_cc = cc_q;
	assign rd_data = regs[rd_addr];
	assign rd_busy = busy[rd_addr];

endmodule

// ==== rtl/commit_top.sv ====
`timescale 1ns/1ps

module commit_top
(
	input logic clk,
	input logic rst_n,
	input logic enq_valid,
	input commit_pkg::rob_entry_t enq_entry,
	output logic credit_return,
	output logic dmem_write,
	output commit_pkg::lc3b_word dmem_addr,
	output commit_pkg::lc3b_word dmem_wdata,
	input logic dmem_resp,
	output logic pc_redirect,
	output commit_pkg::lc3b_word new_pc,
	output logic flush,
	input commit_pkg::lc3b_reg rd_addr,
	output commit_pkg::lc3b_word rd_data,
	output logic rd_busy,
	output commit_pkg::lc3b_nzp committed_cc,
	output commit_pkg::lc3b_word branch_count,
	output commit_pkg::lc3b_word mispredict_count
);

	commit_pkg::rob_idx_t alloc_idx;
	commit_pkg::rob_idx_t head_idx;
	commit_pkg::rob_entry_t head_entry;
	commit_pkg::retire_t retire_info;
	logic head_valid;
	logic retire;
	logic branch_taken;

	reorder_buffer reorder_buffer_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.enq_valid(enq_valid),
		.enq_entry(enq_entry),
		.alloc_idx(alloc_idx),
		.head_valid(head_valid),
		.head_entry(head_entry),
		.head_idx(head_idx),
		.retire(retire),
		.flush(flush),
		.credit_return(credit_return)
	);

	commit_fsm commit_fsm_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.head_valid(head_valid),
		.head_entry(head_entry),
		.head_idx(head_idx),
		.committed_cc(committed_cc),
		.dmem_resp(dmem_resp),
		.retire(retire),
		.retire_info(retire_info),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.pc_redirect(pc_redirect),
		.new_pc(new_pc),
		.flush(flush),
		.branch_taken(branch_taken)
	);

	arch_regfile arch_regfile_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.enq_valid(enq_valid),
		.enq_entry(enq_entry),
		.alloc_idx(alloc_idx),
		.retire(retire),
		.retire_info(retire_info),
		.flush(flush),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_busy(rd_busy),
		.committed_cc(committed_cc)
	);

	branch_stats branch_stats_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.retire(retire),
		.retire_info(retire_info),
		.branch_taken(branch_taken),
		.branch_count(branch_count),
		.mispredict_count(mispredict_count)
	);

endmodule

// ==== bench/commit_tb.sv ====
`timescale 1ns/1ps
`include "commit_macros.svh"

module commit_tb;

	typedef struct packed
	{
		commit_pkg::rob_entry_t entry;
		logic killed;                   // wrong path, flushed before it can retire.
		logic chk;                      // drain the window and check after this row.
		logic chk_busy;                 // store row: rd_busy must be high while it waits.
		logic redir;                    // this row redirects fetch to its value.
		commit_pkg::lc3b_reg reg_idx;
		commit_pkg::lc3b_word val;
		commit_pkg::lc3b_nzp cc;
	} row_t;

	logic clk;
	logic rst_n;
	logic enq_valid;
	commit_pkg::rob_entry_t enq_entry;
	logic credit_return;
	logic dmem_write;
	commit_pkg::lc3b_word dmem_addr;
	commit_pkg::lc3b_word dmem_wdata;
	logic dmem_resp;
	logic pc_redirect;
	commit_pkg::lc3b_word new_pc;
	logic flush;
	commit_pkg::lc3b_reg rd_addr;
	commit_pkg::lc3b_word rd_data;
	logic rd_busy;
	commit_pkg::lc3b_nzp committed_cc;
	commit_pkg::lc3b_word branch_count;
	commit_pkg::lc3b_word mispredict_count;

	row_t rows [$];
	row_t store_q [$];
	int errors = 0;
	int credits = `ROB_DEPTH;
	int redirects = 0;
	int flushes = 0;
	int credit_pulses = 0;
	logic timed_out = 1'b0;
	logic write_seen = 1'b0;
	commit_pkg::lc3b_word last_pc = '0;

	commit_top commit_top_inst
	(
		.clk(clk), .rst_n(rst_n), .enq_valid(enq_valid), .enq_entry(enq_entry),
		.credit_return(credit_return), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_resp(dmem_resp), .pc_redirect(pc_redirect),
		.new_pc(new_pc), .flush(flush), .rd_addr(rd_addr), .rd_data(rd_data),
		.rd_busy(rd_busy), .committed_cc(committed_cc), .branch_count(branch_count),
		.mispredict_count(mispredict_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic add_row(input commit_pkg::lc3b_opcode op, input logic [2:0] dest,
		input logic [15:0] value, input logic [15:0] addr, input logic predict,
		input logic [3:0] flags, input logic [2:0] reg_idx, input logic [15:0] val,
		input logic [2:0] cc);
		row_t r;
		r.entry = '{opcode: op, dest: dest, value: value, addr: addr, predict: predict};
		{r.killed, r.chk, r.chk_busy, r.redir} = flags;
		r.reg_idx = reg_idx;
		r.val = val;
		r.cc = cc;
		rows.push_back(r);
	endtask

	// flags are killed, chk, chk_busy, redir.
	task automatic build_table();
		add_row(commit_pkg::op_add, 3'd1, 16'h0005, 16'h0, 1'b0, 4'b0100, 3'd1, 16'h0005, 3'b001);
		add_row(commit_pkg::op_str, 3'd0, 16'h1234, 16'h3000, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd1, 16'h0007, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_str, 3'd0, 16'hbeef, 16'h3002, 1'b0, 4'b0010, 3'd1, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd1, 16'hfff0, 16'h0, 1'b0, 4'b0100, 3'd1, 16'hfff0, 3'b100);
		add_row(commit_pkg::op_jsr, 3'd2, 16'h0040, 16'h0, 1'b0, 4'b0100, 3'd2, 16'h0040, 3'b100);
		add_row(commit_pkg::op_and, 3'd3, 16'h0000, 16'h0, 1'b0, 4'b0100, 3'd3, 16'h0000, 3'b010);
		add_row(commit_pkg::op_br, 3'b010, 16'h0100, 16'h0, 1'b1, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd4, 16'h0011, 16'h0, 1'b0, 4'b0100, 3'd4, 16'h0011, 3'b001);
		// a burst of eight entries back to back.
		add_row(commit_pkg::op_not, 3'd5, 16'h8000, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd6, 16'h0001, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd0, 16'h0002, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd0, 16'h0003, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_jsr, 3'd2, 16'h0050, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd3, 16'h0004, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd4, 16'h0005, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd5, 16'h0006, 16'h0, 1'b0, 4'b0100, 3'd5, 16'h0006, 3'b001);
		// store holds the branch back so the wrong-path entries get in first.
		add_row(commit_pkg::op_str, 3'd0, 16'h5555, 16'h3004, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_br, 3'b100, 16'h0200, 16'h0, 1'b1, 4'b0001, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd1, 16'h0999, 16'h0, 1'b0, 4'b1000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_add, 3'd1, 16'h0888, 16'h0, 1'b0, 4'b1100, 3'd1, 16'hfff0, 3'b001);
		add_row(commit_pkg::op_br, 3'b100, 16'h0300, 16'h0, 1'b0, 4'b0000, 3'd0, 16'h0, 3'b000);
		add_row(commit_pkg::op_trap, 3'd0, 16'h0400, 16'h0, 1'b0, 4'b0101, 3'd7, 16'h0400, 3'b001);
	endtask

	// one clock, with the credit count updated from what the edge saw.
	task automatic tick();
		@(posedge clk);
		if (flush)
			credits = `ROB_DEPTH;
		else
			credits = credits - int'(enq_valid) + int'(credit_return);
		if (credits < 0 || credits > `ROB_DEPTH)
		begin
			$display("credit count left its range at %0t: %0d", $time, credits);
			errors++;
		end
		enq_valid <= 1'b0;
	endtask

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act)
		begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	initial
	begin
		int i;
		int wait_cycles;
		int exp_redirects;
		int exp_branches;
		int exp_misses;
		int exp_retired;
		commit_pkg::lc3b_word exp_pc;
		void'($urandom(32'h1699));
		rst_n = 1'b0;
		enq_valid = 1'b0;
		enq_entry = '0;
		dmem_resp = 1'b0;
		rd_addr = '0;
		exp_redirects = 0;
		exp_branches = 0;
		exp_misses = 0;
		exp_retired = 0;
		exp_pc = '0;
		build_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (i = 0; i < rows.size(); i++)
		begin
			tick();
			wait_cycles = 0;
			while (credits == 0 && wait_cycles < 100)
			begin
				tick();
				wait_cycles++;
			end
			if (credits == 0)
			begin
				$display("no credit came back for row %0d", i);
				timed_out = 1'b1;
				break;
			end
			enq_valid <= 1'b1;
			enq_entry <= rows[i].entry;
			if (rows[i].entry.opcode == commit_pkg::op_str)
				store_q.push_back(rows[i]);
			if (rows[i].chk_busy)
				rd_addr <= rows[i].reg_idx;
			if (!rows[i].killed)
				exp_retired++;
			if (!rows[i].killed && rows[i].entry.opcode == commit_pkg::op_br)
				exp_branches++;
			if (rows[i].redir)
			begin
				exp_redirects++;
				exp_pc = rows[i].entry.value;
				if (rows[i].entry.opcode == commit_pkg::op_br)
					exp_misses++;
			end
			if (rows[i].chk)
			begin
				tick();
				wait_cycles = 0;
				while (credits != `ROB_DEPTH && wait_cycles < 200)
				begin
					tick();
					wait_cycles++;
				end
				if (credits != `ROB_DEPTH)
				begin
					$display("window did not drain after row %0d", i);
					timed_out = 1'b1;
					break;
				end
				rd_addr <= rows[i].reg_idx;
				tick();
				check_word("rd_data", rows[i].val, rd_data);
				check_word("rd_busy", 16'h0, 16'(rd_busy));
				check_word("committed_cc", 16'(rows[i].cc), 16'(committed_cc));
				check_word("redirect_count", 16'(exp_redirects), 16'(redirects));
				check_word("flush_count", 16'(exp_redirects), 16'(flushes));
				check_word("new_pc", exp_pc, last_pc);
			end
		end
		if (!timed_out)
		begin
			check_word("branch_count", 16'(exp_branches), branch_count);
			check_word("mispredict_count", 16'(exp_misses), mispredict_count);
			check_word("credit_return_total", 16'(exp_retired), 16'(credit_pulses));
		end
		$display("run finished with %0d errors", errors);
		if (errors == 0 && !timed_out)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// memory answers each store after 0 to 4 cycles.
	initial
	begin
		int delay;
		forever
		begin
			@(posedge clk);
			dmem_resp <= 1'b0;
			if (dmem_write && !dmem_resp)
			begin
				delay = int'($urandom % 5);
				repeat (delay) @(posedge clk);
				dmem_resp <= 1'b1;
			end
		end
	end

	// watches stores, redirects, flushes and returned credits.
	always @(posedge clk)
	begin
		if (pc_redirect)
		begin
			redirects++;
			last_pc = new_pc;
		end
		if (flush)
			flushes++;
		if (credit_return)
			credit_pulses++;
		if (dmem_write)
		begin
			if (store_q.size() == 0)
			begin
				$display("store request at %0t with no store in flight", $time);
				errors++;
			end
			else
			begin
				check_word("dmem_addr", store_q[0].entry.addr, dmem_addr);
				check_word("dmem_wdata", store_q[0].entry.value, dmem_wdata);
				if (!write_seen && store_q[0].chk_busy)
					check_word("rd_busy", 16'h1, 16'(rd_busy));     // newer producer still out.
				if (dmem_resp)
					void'(store_q.pop_front());
			end
		end
		write_seen = dmem_write && !dmem_resp;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/commit_pkg.sv
rtl/reorder_buffer.sv
rtl/commit_fsm.sv
rtl/branch_stats.sv
rtl/arch_regfile.sv
rtl/commit_top.sv
bench/commit_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the commit stage testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f verilog.f \
	--top-module commit_tb \
	-Mdir obj_dir -o commit_sim

./obj_dir/commit_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
